// ==== Makefile ====
SIM = obj_dir/mmioPeriphSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module mmioPeriphTb -o mmioPeriphSim

run: compile
	./$(SIM) > run.log 2>&1; cat run.log
	@if grep -q "Verification failed" run.log; then exit 1; fi
	@grep -q "Verification passed" run.log

clean:
	rm -rf obj_dir run.log

// ==== hw/mmioBusPkg.sv ====
package mmioBusPkg;

	// bus data and address widths
	typedef logic [63:0] mmioData;
	typedef logic [31:0] mmioAddrT;

	// operation mode: read, write and access size
	typedef logic [4:0] mmioOpmT;

	// slave response code
	typedef logic [1:0] mmioOkT;

	localparam int opmReadBit = 3;
	localparam int opmWriteBit = 4;
	localparam logic [1:0] opmSizeQuad = 2'd3;

	// response values
	localparam mmioOkT okReady = 2'b00;
	localparam mmioOkT okOk = 2'b01;
	localparam mmioOkT okHold = 2'b10;
	localparam mmioOkT okFault = 2'b11;

	// the 64 KiB window is selected when these address bits are zero
	localparam logic [11:0] mmioWindowSel = 12'h000;

	// register offsets inside the window
	localparam logic [15:0] regTimerLo = 16'hE000;
	localparam logic [15:0] regTimerHi = 16'hE004;
	localparam logic [15:0] regUartRx = 16'hE010;
	localparam logic [15:0] regUartTx = 16'hE014;
	localparam logic [15:0] regUartStat = 16'hE018;
	localparam logic [15:0] regBounce = 16'hE080;
	localparam logic [15:0] regGpioIn = 16'hE100;
	localparam logic [15:0] regGpioOut = 16'hE104;
	localparam logic [15:0] regGpioDir = 16'hE108;
	localparam logic [15:0] regGpioSet = 16'hE110;
	localparam logic [15:0] regGpioClr = 16'hE114;

endpackage

// ==== hw/mmioPeriphRegs.sv ====
`timescale 1ns/10ps

module mmioPeriphRegs
	import mmioBusPkg::*;
	import periphPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  mmioData  mmioInData,
	input  mmioAddrT mmioAddr,
	input  mmioOpmT  mmioOpm,
	output mmioData  mmioOutData,
	output mmioOkT   mmioOK,
	input  gpioWord  gpioPinsIn,
	output gpioWord  gpioPinsOut,
	output gpioWord  gpioPinsDir,
	input  timerWord timerUs,
	output mmioData  bounceIrq,
	output logic     txPush,
	output uartByte  txPushData,
	output logic     rxPop,
	input  logic     txFull,
	input  logic     txEmpty,
	input  uartByte  rxHead,
	input  logic     rxReady,
	input  logic     rxFull
);

	// registered copy of the request
	mmioData reqData;
	mmioAddrT reqAddr;
	mmioOpmT reqOpm;

	logic [15:0] offset;
	logic chipSel;
	logic readEn;
	logic writeEn;
	logic quadAccess;
	logic lastRead;
	logic lastWrite;
	logic readRise;
	logic writeRise;
	logic hit;

	mmioOkT okNext;
	mmioData dataNext;
	mmioData bounceNext;
	gpioWord gpioOut;
	gpioWord gpioDir;
	gpioWord gpioOutNext;
	gpioWord gpioDirNext;
	uartByte rxLatch;

	assign gpioPinsOut = gpioOut;
	assign gpioPinsDir = gpioDir;

	assign offset = reqAddr[15:0];
	assign chipSel = reqAddr[27:16] == mmioWindowSel;
	assign readEn = reqOpm[opmReadBit] && chipSel;
	assign writeEn = reqOpm[opmWriteBit] && chipSel;
	assign quadAccess = reqOpm[1:0] == opmSizeQuad;

	// first cycle of a held request
	assign readRise = readEn && !lastRead;
	assign writeRise = writeEn && !lastWrite;

	// FIFO side effects happen once per request
	assign txPush = writeRise && offset == regUartTx;
	assign txPushData = reqData[7:0];
	assign rxPop = readRise && offset == regUartRx;
	assign bounceNext = (writeRise && offset == regBounce) ? reqData : '0;

	always_comb
	begin
		hit = 1'b1;
		dataNext = '0;
		gpioOutNext = gpioOut;
		gpioDirNext = gpioDir;
		case (offset)
			regTimerLo:
				dataNext = quadAccess ? timerUs : {32'h0, timerUs[31:0]};
			regTimerHi:
				dataNext = {32'h0, timerUs[63:32]};
			regUartRx:
				// head is captured on the pop so the answer holds steady
				dataNext = {56'h0, rxPop ? rxHead : rxLatch};
			regUartTx:
				dataNext = '0;
			regUartStat:
				dataNext = {60'h0, txFull, txEmpty, rxFull, rxReady};
			regBounce:
				dataNext = '0;
			regGpioIn:
				dataNext = {32'h0, gpioPinsIn};
			regGpioOut:
			begin
				dataNext = {32'h0, gpioOut};
				if (writeEn)
					gpioOutNext = reqData[31:0];
			end
			regGpioDir:
			begin
				dataNext = {32'h0, gpioDir};
				if (writeEn)
					gpioDirNext = reqData[31:0];
			end
			regGpioSet:
			begin
				dataNext = {32'h0, gpioOut};
				if (writeEn)
					gpioOutNext = gpioOut | reqData[31:0];
			end
			regGpioClr:
			begin
				dataNext = {32'h0, gpioOut};
				if (writeEn)
					gpioOutNext = gpioOut & ~reqData[31:0];
			end
			default:
				hit = 1'b0;
		endcase
		// unmapped offsets never answer
		okNext = (hit && (readEn || writeEn)) ? okOk : okReady;
	end

	always_ff @(posedge clock)
	begin
		reqData <= mmioInData;
		reqAddr <= mmioAddr;
		mmioOutData <= dataNext;
		if (rxPop)
			rxLatch <= rxHead;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqOpm <= '0;
			lastRead <= 1'b0;
			lastWrite <= 1'b0;
			mmioOK <= okReady;
			gpioOut <= '0;
			gpioDir <= '0;
			bounceIrq <= '0;
		end
		else
		begin
			reqOpm <= mmioOpm;
			lastRead <= readEn;
			lastWrite <= writeEn;
			mmioOK <= okNext;
			gpioOut <= gpioOutNext;
			gpioDir <= gpioDirNext;
			bounceIrq <= bounceNext;
		end
	end

endmodule

// ==== hw/mmioPeriphTop.sv ====
`timescale 1ns/10ps

module mmioPeriphTop
	import mmioBusPkg::*;
	import periphPkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  mmioData     mmioInData,
	input  mmioAddrT    mmioAddr,
	input  mmioOpmT     mmioOpm,
	output mmioData     mmioOutData,
	output mmioOkT      mmioOK,
	input  gpioWord     gpioPinsIn,
	output gpioWord     gpioPinsOut,
	output gpioWord     gpioPinsDir,
	input  logic [15:0] fixedPinsIn,
	output logic [15:0] fixedPinsOut,
	output timerWord    outTimer1MHz,
	output timerWord    outTimer100MHz,
	output mmioData     outBounceIrq
);

	logic usStep;
	timerWord timerUs;
	logic txPush;
	uartByte txPushData;
	logic txFull;
	logic txEmpty;
	logic txLine;
	logic rxPop;
	uartByte rxHead;
	logic rxReady;
	logic rxFull;

	assign outTimer1MHz = timerUs;

	// bit 0 drives UART TX, the rest float
	assign fixedPinsOut = {{15{1'bz}}, txLine};

	periphTimebase timebase (
		.clock      (clock),
		.reset      (reset),
		.usStep     (usStep),
		.timerUs    (timerUs),
		.timerCycles(outTimer100MHz)
	);

	mmioPeriphRegs regs (
		.clock      (clock),
		.reset      (reset),
		.mmioInData (mmioInData),
		.mmioAddr   (mmioAddr),
		.mmioOpm    (mmioOpm),
		.mmioOutData(mmioOutData),
		.mmioOK     (mmioOK),
		.gpioPinsIn (gpioPinsIn),
		.gpioPinsOut(gpioPinsOut),
		.gpioPinsDir(gpioPinsDir),
		.timerUs    (timerUs),
		.bounceIrq  (outBounceIrq),
		.txPush     (txPush),
		.txPushData (txPushData),
		.rxPop      (rxPop),
		.txFull     (txFull),
		.txEmpty    (txEmpty),
		.rxHead     (rxHead),
		.rxReady    (rxReady),
		.rxFull     (rxFull)
	);

	uartTransmitter uartTx (
		.clock     (clock),
		.reset     (reset),
		.usStep    (usStep),
		.txPush    (txPush),
		.txPushData(txPushData),
		.txFull    (txFull),
		.txEmpty   (txEmpty),
		.txLine    (txLine)
	);

	// UART RX comes in on fixed pin 1
	uartReceiver uartRx (
		.clock  (clock),
		.reset  (reset),
		.usStep (usStep),
		.rxLine (fixedPinsIn[1]),
		.rxPop  (rxPop),
		.rxHead (rxHead),
		.rxReady(rxReady),
		.rxFull (rxFull)
	);

endmodule

// ==== hw/periphPkg.sv ====
package periphPkg;

	typedef logic [7:0] uartByte;
	typedef logic [31:0] gpioWord;
	typedef logic [63:0] timerWord;
	typedef logic [15:0] fracWord;

	// bit position inside a UART frame
	typedef logic [3:0] uartBitPos;

	// shared by both UART halves
	typedef enum logic {
		uartIdle,
		uartBusy
	} uartState;

	// 65536 / 0x0290 is about 100 clocks per microsecond (100 MHz clock)
	localparam fracWord usFracStep = 16'h0290;

	// per microsecond, gives roughly 115200 baud
	localparam fracWord baudFracStep = 16'h1D7E;

	localparam int uartFifoDepth = 8;

	// frame layout: start at 0, data at 1..8, stop at 9
	localparam uartBitPos uartLastDataPos = 4'd8;
	localparam uartBitPos uartStopPos = 4'd9;

endpackage

// ==== hw/periphTimebase.sv ====
`timescale 1ns/10ps

module periphTimebase
	import periphPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	output logic     usStep,
	output timerWord timerUs,
	output timerWord timerCycles
);

	fracWord usFrac;
	fracWord usFracNext;

	// carry out of the fractional accumulator marks one microsecond
	always_comb
	begin
		{usStep, usFracNext} = {1'b0, usFrac} + {1'b0, usFracStep};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			usFrac <= '0;
			timerUs <= '0;
			timerCycles <= '0;
		end
		else
		begin
			usFrac <= usFracNext;
			timerCycles <= timerCycles + 64'd1;
			if (usStep)
				timerUs <= timerUs + 64'd1;
		end
	end

endmodule

// ==== hw/uartReceiver.sv ====
`timescale 1ns/10ps

module uartReceiver
	import periphPkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    usStep,
	input  logic    rxLine,
	input  logic    rxPop,
	output uartByte rxHead,
	output logic    rxReady,
	output logic    rxFull
);

	uartByte fifoData [uartFifoDepth];
	uartByte fifoDataNext [uartFifoDepth];
	logic [uartFifoDepth-1:0] fifoValid;
	logic [uartFifoDepth-1:0] fifoValidNext;

	logic rxSync;
	logic rxLast;
	uartState state;
	uartBitPos bitPos;
	fracWord baudFrac;
	fracWord baudFracNext;
	logic baudStep;
	logic midSample;
	logic startBit;
	logic falseStart;
	logic byteDone;
	uartByte shiftData;

	assign rxHead = fifoData[0];
	assign rxReady = fifoValid[0];
	assign rxFull = fifoValid[uartFifoDepth-1];

	// falling edge on an idle line
	assign startBit = (state == uartIdle) && rxLast && !rxSync;

	always_comb
	begin
		{baudStep, baudFracNext} = {1'b0, baudFrac} + {1'b0, baudFracStep};
	end

	// accumulator crossing its midpoint is the centre of a bit
	assign midSample = usStep && baudFracNext[15] && !baudFrac[15];
	assign falseStart = midSample && bitPos == '0 && rxSync;
	assign byteDone = (state == uartBusy) && usStep && baudStep && bitPos == uartLastDataPos;

	always_comb
	begin
		logic placed;
		placed = 1'b0;
		fifoDataNext = fifoData;
		fifoValidNext = fifoValid;
		if (rxPop)
		begin
			for (int i = 0; i < uartFifoDepth - 1; i++)
			begin
				fifoDataNext[i] = fifoData[i + 1];
				fifoValidNext[i] = fifoValid[i + 1];
			end
			fifoValidNext[uartFifoDepth-1] = 1'b0;
		end
		// a byte that finds no free slot is dropped
		for (int i = 0; i < uartFifoDepth; i++)
		begin
			if (byteDone && !placed && !fifoValidNext[i])
			begin
				fifoDataNext[i] = shiftData;
				fifoValidNext[i] = 1'b1;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		fifoData <= fifoDataNext;
		// LSB arrives first, so shift in from the top
		if (state == uartBusy && midSample && bitPos != '0)
			shiftData <= {rxSync, shiftData[7:1]};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rxSync <= 1'b1;
			rxLast <= 1'b1;
			fifoValid <= '0;
			state <= uartIdle;
			bitPos <= '0;
			baudFrac <= '0;
		end
		else
		begin
			rxSync <= rxLine;
			rxLast <= rxSync;
			fifoValid <= fifoValidNext;
			if (startBit)
			begin
				state <= uartBusy;
				bitPos <= '0;
				baudFrac <= '0;
			end
			else if (state == uartBusy && usStep)
			begin
				baudFrac <= baudFracNext;
				// start bit gone high again by mid-bit, treat as a glitch
				if (falseStart)
					state <= uartIdle;
				else if (baudStep)
				begin
					if (bitPos == uartLastDataPos)
						state <= uartIdle;
					bitPos <= bitPos + 4'd1;
				end
			end
		end
	end

endmodule

// ==== hw/uartTransmitter.sv ====
`timescale 1ns/10ps

module uartTransmitter
	import periphPkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    usStep,
	input  logic    txPush,
	input  uartByte txPushData,
	output logic    txFull,
	output logic    txEmpty,
	output logic    txLine
);

	uartByte fifoData [uartFifoDepth];
	uartByte fifoDataNext [uartFifoDepth];
	logic [uartFifoDepth-1:0] fifoValid;
	logic [uartFifoDepth-1:0] fifoValidNext;

	uartByte holdData;
	logic holdValid;
	logic holdValidNext;

	uartState state;
	uartBitPos bitPos;
	fracWord baudFrac;
	fracWord baudFracNext;
	logic baudStep;
	uartByte shiftData;
	logic startFrame;
	logic lineNext;

	assign txFull = fifoValid[uartFifoDepth-1];
	assign txEmpty = !fifoValid[0] && !holdValid;

	// head leaves the FIFO as soon as the line is free
	assign startFrame = (state == uartIdle) && fifoValid[0];

	always_comb
	begin
		{baudStep, baudFracNext} = {1'b0, baudFrac} + {1'b0, baudFracStep};
	end

	always_comb
	begin
		logic placed;
		placed = 1'b0;
		fifoDataNext = fifoData;
		fifoValidNext = fifoValid;
		if (startFrame)
		begin
			for (int i = 0; i < uartFifoDepth - 1; i++)
			begin
				fifoDataNext[i] = fifoData[i + 1];
				fifoValidNext[i] = fifoValid[i + 1];
			end
			fifoValidNext[uartFifoDepth-1] = 1'b0;
		end
		// hold byte drops into the first free slot after the shift
		for (int i = 0; i < uartFifoDepth; i++)
		begin
			if (holdValid && !placed && !fifoValidNext[i])
			begin
				fifoDataNext[i] = holdData;
				fifoValidNext[i] = 1'b1;
				placed = 1'b1;
			end
		end
		holdValidNext = holdValid && !placed;
	end

	// start bit low, data from shiftData[0], stop bit and idle high
	always_comb
	begin
		lineNext = 1'b1;
		if (state == uartBusy)
		begin
			if (bitPos == '0)
				lineNext = 1'b0;
			else if (bitPos != uartStopPos)
				lineNext = shiftData[0];
		end
	end

	always_ff @(posedge clock)
	begin
		fifoData <= fifoDataNext;
		if (txPush && !holdValidNext)
			holdData <= txPushData;
		if (startFrame)
			shiftData <= fifoData[0];
		else if (usStep && baudStep && bitPos != '0)
			shiftData <= shiftData >> 1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fifoValid <= '0;
			holdValid <= 1'b0;
			state <= uartIdle;
			bitPos <= '0;
			baudFrac <= '0;
			txLine <= 1'b1;
		end
		else
		begin
			fifoValid <= fifoValidNext;
			// a push onto a still-full hold register is lost
			holdValid <= holdValidNext || txPush;
			txLine <= lineNext;
			if (startFrame)
			begin
				state <= uartBusy;
				bitPos <= '0;
				baudFrac <= '0;
			end
			else if (state == uartBusy && usStep)
			begin
				baudFrac <= baudFracNext;
				if (baudStep)
				begin
					if (bitPos == uartStopPos)
						state <= uartIdle;
					else
						bitPos <= bitPos + 4'd1;
				end
			end
		end
	end

endmodule

// ==== tb/mmioPeriphTasks.svh ====
`ifndef MMIO_PERIPH_TASKS_SVH
`define MMIO_PERIPH_TASKS_SVH

// Galois LFSR, one step per bit taken
function automatic logic [63:0] randomBits(input int count);
	logic [63:0] value;
	logic outBit;
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		outBit = lfsrState[0];
		lfsrState = {1'b0, lfsrState[31:1]};
		if (outBit)
			lfsrState = lfsrState ^ 32'h8020_0003;
		value = {value[62:0], outBit};
	end
	return value;
endfunction

function automatic mmioOpmT busOpm(input bit write, input bit quad);
	mmioOpmT opm;
	opm = '0;
	if (write)
		opm[opmWriteBit] = 1'b1;
	else
		opm[opmReadBit] = 1'b1;
	opm[1:0] = quad ? opmSizeQuad : 2'd2;
	return opm;
endfunction

task automatic checkValue(input string name, input logic [63:0] actual,
	input logic [63:0] expected);
	checkCount++;
	assert (actual === expected)
	else
	begin
		$display("Error: %s is %h, expected %h", name, actual, expected);
		errorCount++;
	end
endtask

// microseconds times 65536 against cycles times the fractional step
task automatic checkUsDelta(input string name, input longint usDelta, input longint cycles);
	longint expectedScaled;
	expectedScaled = cycles * longint'(usFracStep);
	checkCount++;
	assert (usDelta * 65536 - expectedScaled <= 65536
		&& expectedScaled - usDelta * 65536 <= 65536)
	else
	begin
		$display("Error: %s is %h, expected within one of %h", name, usDelta,
			expectedScaled / 65536);
		errorCount++;
	end
endtask

task automatic expectTrue(input bit condition, input string what);
	checkCount++;
	assert (condition)
	else
	begin
		$display("Failed: %s", what);
		errorCount++;
	end
endtask

task automatic reportTest(input string name, input int errorsBefore);
	testCount++;
	$display("Test %s finished with %0d errors", name, errorCount - errorsBefore);
endtask

// request held as levels until okOk, then opm back to zero
task automatic busAccess(input mmioOpmT opm, input mmioAddrT addr, input mmioData data,
	output mmioData readData, output bit answered);
	int waited;
	@(posedge clock);
	#1;
	mmioOpm = opm;
	mmioAddr = addr;
	mmioInData = data;
	answered = 1'b0;
	waited = 0;
	while (!answered && waited < busTimeout)
	begin
		@(posedge clock);
		#1;
		waited++;
		if (mmioOK == okOk)
			answered = 1'b1;
	end
	readData = mmioOutData;
	mmioOpm = '0;
endtask

task automatic busRead(input logic [15:0] offset, input bit quad, output mmioData readData);
	bit answered;
	busAccess(busOpm(1'b0, quad), {16'h0, offset}, '0, readData, answered);
	if (!answered)
		expectTrue(1'b0, $sformatf("read at offset %h got no okOk in time", offset));
endtask

task automatic busWrite(input logic [15:0] offset, input mmioData data);
	mmioData unused;
	bit answered;
	busAccess(busOpm(1'b1, 1'b1), {16'h0, offset}, data, unused, answered);
	if (!answered)
		expectTrue(1'b0, $sformatf("write at offset %h got no okOk in time", offset));
endtask

// poll rxReady, then pop the head through regUartRx
task automatic receiveByte(output mmioData readData, output bit ok);
	longint start;
	mmioData status;
	start = cycleCount;
	ok = 1'b0;
	readData = '0;
	while (!ok && cycleCount - start < uartTimeout)
	begin
		busRead(regUartStat, 1'b0, status);
		if (status[0])
			ok = 1'b1;
	end
	expectTrue(ok, "no byte arrived at the UART receiver in time");
	if (ok)
		busRead(regUartRx, 1'b0, readData);
endtask

task automatic uartStatusTest();
	uartByte pushed[$];
	uartByte value;
	mmioData status;
	mmioData got;
	bit ok;
	// TX line idles high out of reset
	checkValue("fixedPinsOut[0]", {63'h0, fixedPinsOut[0]}, 64'h1);
	busRead(regUartStat, 1'b0, status);
	checkValue("regUartStat", status, 64'h4);
	// one goes straight to the serializer, eight fill the FIFO
	repeat (9)
	begin
		value = uartByte'(randomBits(8));
		pushed.push_back(value);
		busWrite(regUartTx, {56'h0, value});
	end
	busRead(regUartStat, 1'b0, status);
	checkValue("regUartStat", status, 64'h8);
	while (pushed.size() > 0)
	begin
		receiveByte(got, ok);
		if (!ok)
			break;
		checkValue("regUartRx", got, {56'h0, pushed.pop_front()});
	end
endtask

task automatic timerTest();
	mmioData first;
	mmioData second;
	mmioData upper;
	mmioData lowWord;
	longint firstCycle;
	longint secondCycle;
	longint elapsed;
	timerWord cyclesA;
	timerWord usA;
	busRead(regTimerLo, 1'b1, first);
	firstCycle = cycleCount;
	cyclesA = outTimer100MHz;
	usA = outTimer1MHz;
	repeat (timerGap)
		@(posedge clock);
	busRead(regTimerLo, 1'b1, second);
	secondCycle = cycleCount;
	elapsed = secondCycle - firstCycle;
	checkValue("outTimer100MHz delta", outTimer100MHz - cyclesA, elapsed);
	checkUsDelta("regTimerLo delta", longint'(second - first), elapsed);
	checkUsDelta("outTimer1MHz delta", longint'(outTimer1MHz - usA), elapsed);
	busRead(regTimerHi, 1'b0, upper);
	checkValue("regTimerHi", upper, {32'h0, second[63:32]});
	busRead(regTimerLo, 1'b0, lowWord);
	checkUsDelta("regTimerLo low word delta",
		longint'(lowWord - {32'h0, second[31:0]}), cycleCount - secondCycle);
endtask

task automatic gpioTest();
	gpioWord outValue;
	gpioWord dirValue;
	gpioWord mask;
	gpioWord inValue;
	mmioData readBack;
	outValue = gpioWord'(randomBits(32));
	dirValue = gpioWord'(randomBits(32));
	busWrite(regGpioOut, {32'h0, outValue});
	busWrite(regGpioDir, {32'h0, dirValue});
	checkValue("gpioPinsOut", {32'h0, gpioPinsOut}, {32'h0, outValue});
	checkValue("gpioPinsDir", {32'h0, gpioPinsDir}, {32'h0, dirValue});
	busRead(regGpioOut, 1'b0, readBack);
	checkValue("regGpioOut", readBack, {32'h0, outValue});
	busRead(regGpioDir, 1'b0, readBack);
	checkValue("regGpioDir", readBack, {32'h0, dirValue});
	mask = gpioWord'(randomBits(32));
	outValue = outValue | mask;
	busWrite(regGpioSet, {32'h0, mask});
	checkValue("gpioPinsOut", {32'h0, gpioPinsOut}, {32'h0, outValue});
	mask = gpioWord'(randomBits(32));
	outValue = outValue & ~mask;
	busWrite(regGpioClr, {32'h0, mask});
	checkValue("gpioPinsOut", {32'h0, gpioPinsOut}, {32'h0, outValue});
	busRead(regGpioOut, 1'b0, readBack);
	checkValue("regGpioOut", readBack, {32'h0, outValue});
	inValue = gpioWord'(randomBits(32));
	gpioPinsIn = inValue;
	busRead(regGpioIn, 1'b0, readBack);
	checkValue("regGpioIn", readBack, {32'h0, inValue});
endtask

task automatic uartLoopbackTest();
	uartByte sent[$];
	uartByte value;
	mmioData got;
	bit ok;
	repeat (5)
	begin
		value = uartByte'(randomBits(8));
		sent.push_back(value);
		busWrite(regUartTx, {56'h0, value});
	end
	while (sent.size() > 0)
	begin
		receiveByte(got, ok);
		if (!ok)
			break;
		checkValue("regUartRx", got, {56'h0, sent.pop_front()});
	end
	busRead(regUartStat, 1'b0, got);
	checkValue("rxReady", {63'h0, got[0]}, 64'h0);
	checkValue("txEmpty", {63'h0, got[2]}, 64'h1);
endtask

task automatic bounceTest();
	mmioData pulse;
	pulse = randomBits(64);
	@(posedge clock);
	#1;
	mmioOpm = busOpm(1'b1, 1'b1);
	mmioAddr = {16'h0, regBounce};
	mmioInData = pulse;
	// edge N registers the request
	@(posedge clock);
	#1;
	checkValue("outBounceIrq", outBounceIrq, '0);
	@(posedge clock);
	#1;
	checkValue("mmioOK", {62'h0, mmioOK}, {62'h0, okOk});
	checkValue("outBounceIrq", outBounceIrq, pulse);
	mmioOpm = '0;
	@(posedge clock);
	#1;
	checkValue("outBounceIrq", outBounceIrq, '0);
endtask

task automatic decodeTest();
	mmioData unused;
	bit answered;
	busAccess(busOpm(1'b0, 1'b0), 32'h0000_E020, '0, unused, answered);
	expectTrue(!answered, "read at unmapped offset E020 was answered");
	busAccess(busOpm(1'b0, 1'b0), {4'h0, 12'h010, regGpioOut}, '0, unused, answered);
	expectTrue(!answered, "read with address bits 27:16 nonzero was answered");
endtask

`endif

// ==== tb/mmioPeriphTb.sv ====
`timescale 1ns/10ps

module mmioPeriphTb
	import mmioBusPkg::*;
	import periphPkg::*;
();

	localparam int busTimeout = 20;
	localparam int uartTimeout = 200000;
	localparam int timerGap = 2000;
	localparam int resetCycles = 10;

	logic clock;
	logic reset;
	mmioData mmioInData;
	mmioAddrT mmioAddr;
	mmioOpmT mmioOpm;
	mmioData mmioOutData;
	mmioOkT mmioOK;
	gpioWord gpioPinsIn;
	gpioWord gpioPinsOut;
	gpioWord gpioPinsDir;
	logic [15:0] fixedPinsIn;
	logic [15:0] fixedPinsOut;
	timerWord outTimer1MHz;
	timerWord outTimer100MHz;
	mmioData outBounceIrq;

	logic [31:0] lfsrState;
	longint cycleCount = 0;
	int checkCount;
	int errorCount;
	int testCount;
	int testErrors;

	// UART TX looped straight back into RX
	assign fixedPinsIn = {14'h0, fixedPinsOut[0], 1'b0};

	mmioPeriphTop uut (
		.clock         (clock),
		.reset         (reset),
		.mmioInData    (mmioInData),
		.mmioAddr      (mmioAddr),
		.mmioOpm       (mmioOpm),
		.mmioOutData   (mmioOutData),
		.mmioOK        (mmioOK),
		.gpioPinsIn    (gpioPinsIn),
		.gpioPinsOut   (gpioPinsOut),
		.gpioPinsDir   (gpioPinsDir),
		.fixedPinsIn   (fixedPinsIn),
		.fixedPinsOut  (fixedPinsOut),
		.outTimer1MHz  (outTimer1MHz),
		.outTimer100MHz(outTimer100MHz),
		.outBounceIrq  (outBounceIrq)
	);

	`include "mmioPeriphTasks.svh"

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	// reference cycle count for the timer test and the UART timeouts
	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	initial
	begin
		lfsrState = 32'he10f_66ef;
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		reset = 1'b1;
		mmioInData = '0;
		mmioAddr = '0;
		mmioOpm = '0;
		gpioPinsIn = '0;
		repeat (resetCycles)
			@(posedge clock);
		#1;
		reset = 1'b0;

		// must run first, it looks at the flags straight after reset
		testErrors = errorCount;
		uartStatusTest();
		reportTest("UART status", testErrors);

		testErrors = errorCount;
		timerTest();
		reportTest("timer", testErrors);

		testErrors = errorCount;
		gpioTest();
		reportTest("GPIO", testErrors);

		testErrors = errorCount;
		uartLoopbackTest();
		reportTest("UART loopback", testErrors);

		testErrors = errorCount;
		bounceTest();
		reportTest("bounce", testErrors);

		testErrors = errorCount;
		decodeTest();
		reportTest("decode", testErrors);

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+tb
hw/mmioBusPkg.sv
hw/periphPkg.sv
hw/periphTimebase.sv
hw/uartTransmitter.sv
hw/uartReceiver.sv
hw/mmioPeriphRegs.sv
hw/mmioPeriphTop.sv
tb/mmioPeriphTb.sv
